/* sources.f */
+incdir+.
soc_pkg.sv
word_ram.sv
bytes_conv.sv
gpio_top.sv
ticker.sv
dbus.sv
soc_dbus_top.sv
tb_soc_dbus.sv

/* Makefile */
TOP = tb_soc_dbus

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ns --top-module $(TOP) -f sources.f

sim:
	verilator --binary --timing --timescale 1ns/1ns --top-module $(TOP) -f sources.f
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

/* tb_soc_dbus.sv */
`timescale 1ns/1ns
`default_nettype none

`include "soc_defines.svh"

module tb_soc_dbus;
    import soc_pkg::*;

    typedef enum logic [2:0] {
        OP_WR,
        OP_RD,
        OP_PIN,   // drive gpio_i with the data word
        OP_IDLE,  // strobes low, the data word holds the number of cycles
        OP_PINCHK // compare gpio_o and gpio_oe_o with the reference
    } op_t;

    typedef enum logic [1:0] {
        CK_NONE,
        CK_VAL,
        CK_REF,
        CK_DELTA
    } chk_t;

    typedef struct packed {
        op_t      op;
        addr_t    addr;
        byte_en_t be;
        word_t    data;
        logic     rnd; // take the data word from the xorshift generator
        chk_t     chk;
    } entry_t;

    logic     clk = 1'b0;
    logic     arst_n;
    bus_req_t m_req;
    bus_rsp_t m_rsp;
    word_t    gpio_in;
    word_t    gpio_out;
    word_t    gpio_oe;

    entry_t   tbl [$];
    string    tbl_name [$];
    int       table_len = 0;
    int       cyc = 0;
    int       n_checks = 0;
    int       n_errors = 0;
    word_t    rng;

    // reference state of RAM and peripherals, kept from the bus rules
    word_t    ram_m [`SOC_RAM_WORDS];
    word_t    out_m;
    word_t    dir_m;
    word_t    pin_m;
    word_t    count_m; // only valid while the ticker is disabled
    logic     en_m;
    word_t    tick_ref_val;
    int       tick_ref_cyc;

    soc_dbus_top DUT (
        .clk_i     (clk),
        .arst_n_i  (arst_n),
        .m_req_i   (m_req),
        .m_rsp_o   (m_rsp),
        .gpio_i    (gpio_in),
        .gpio_o    (gpio_out),
        .gpio_oe_o (gpio_oe)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic word_t xorshift32(input word_t x);
        word_t s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic void add_entry(input string name, input op_t op, input addr_t addr,
                                      input byte_en_t be, input word_t data, input logic rnd,
                                      input chk_t chk);
        entry_t e;
        e = '{op, addr, be, data, rnd, chk};
        tbl.push_back(e);
        tbl_name.push_back(name);
    endfunction

    // RAM reads take 2 cycles, partial RAM writes 3, everything else 1
    function automatic int expected_cycles(input logic is_rd, input addr_t a,
                                           input byte_en_t be);
        if (a[31:28] != `SOC_SEL_RAM) begin
            return 1;
        end
        if (is_rd) begin
            return 2;
        end
        return (be == 4'hF) ? 1 : 3;
    endfunction

    function automatic word_t expected_read(input addr_t a);
        word_t v;
        v = '0;
        case (a[31:28])
            `SOC_SEL_RAM: v = ram_m[a[`SOC_RAM_AW+1:2]];
            `SOC_SEL_GPIO: begin
                case (a[7:0])
                    `GPIO_REG_OUT: v = out_m;
                    `GPIO_REG_DIR: v = dir_m;
                    `GPIO_REG_IN:  v = pin_m; // table waits for the synchronizer first
                    default:       v = '0;
                endcase
            end
            `SOC_SEL_TICK: begin
                case (a[7:0])
                    `TICK_REG_COUNT: v = count_m;
                    `TICK_REG_CTRL:  v = {31'd0, en_m};
                    default:         v = '0;
                endcase
            end
            default: v = '0;
        endcase
        return v;
    endfunction

    function automatic void apply_write(input addr_t a, input byte_en_t be, input word_t d);
        word_t w;
        case (a[31:28])
            `SOC_SEL_RAM: begin
                w = ram_m[a[`SOC_RAM_AW+1:2]];
                for (int n = 0; n < 4; n++) begin
                    if (be[n]) begin
                        w[8*n +: 8] = d[8*n +: 8];
                    end
                end
                ram_m[a[`SOC_RAM_AW+1:2]] = w;
            end
            `SOC_SEL_GPIO: begin
                if (a[7:0] == `GPIO_REG_OUT) begin
                    out_m = d;
                end
                if (a[7:0] == `GPIO_REG_DIR) begin
                    dir_m = d;
                end
            end
            `SOC_SEL_TICK: begin
                if (a[7:0] == `TICK_REG_COUNT) begin
                    count_m = d;
                end
                if (a[7:0] == `TICK_REG_CTRL) begin
                    en_m = d[0];
                end
            end
            default: ; // writes to unmapped space go nowhere
        endcase
    endfunction

    function automatic void build_table();
        add_entry("rst_pins", OP_PINCHK, 32'h0, 4'h0, 32'h0, 1'b0, CK_NONE);
        add_entry("rst_tick", OP_RD, 32'hC000_0000, 4'hF, 32'h0, 1'b0, CK_VAL);
        add_entry("ram_wr0", OP_WR, 32'h0000_0000, 4'hF, 32'h0, 1'b1, CK_NONE);
        add_entry("ram_wr1", OP_WR, 32'h0000_0004, 4'hF, 32'h0, 1'b1, CK_NONE);
        add_entry("ram_wr2", OP_WR, 32'h0000_0010, 4'hF, 32'h0, 1'b1, CK_NONE);
        add_entry("ram_wr3", OP_WR, 32'h0000_0FFC, 4'hF, 32'h0, 1'b1, CK_NONE);
        add_entry("ram_wr4", OP_WR, 32'h0000_0100, 4'hF, 32'h0, 1'b1, CK_NONE);
        add_entry("ram_rd0", OP_RD, 32'h0000_0000, 4'hF, 32'h0, 1'b0, CK_VAL);
        add_entry("ram_rd1", OP_RD, 32'h0000_0004, 4'hF, 32'h0, 1'b0, CK_VAL);
        add_entry("ram_rd2", OP_RD, 32'h0000_0010, 4'hF, 32'h0, 1'b0, CK_VAL);
        add_entry("ram_rd3", OP_RD, 32'h0000_0FFC, 4'hF, 32'h0, 1'b0, CK_VAL);
        add_entry("ram_rd4", OP_RD, 32'h0000_0100, 4'hF, 32'h0, 1'b0, CK_VAL);
        add_entry("ram_pw_0001", OP_WR, 32'h0000_0004, 4'b0001, 32'h0, 1'b1, CK_NONE);
        add_entry("ram_rd_0001", OP_RD, 32'h0000_0004, 4'hF, 32'h0, 1'b0, CK_VAL);
        add_entry("ram_pw_0110", OP_WR, 32'h0000_0010, 4'b0110, 32'h0, 1'b1, CK_NONE);
        add_entry("ram_rd_0110", OP_RD, 32'h0000_0010, 4'hF, 32'h0, 1'b0, CK_VAL);
        add_entry("ram_pw_1000", OP_WR, 32'h0000_0FFC, 4'b1000, 32'h0, 1'b1, CK_NONE);
        add_entry("ram_rd_1000", OP_RD, 32'h0000_0FFC, 4'hF, 32'h0, 1'b0, CK_VAL);
        add_entry("ram_pw_b2b_hi", OP_WR, 32'h0000_0100, 4'b1000, 32'h0, 1'b1, CK_NONE);
        add_entry("ram_pw_b2b_lo", OP_WR, 32'h0000_0100, 4'b0001, 32'h0, 1'b1, CK_NONE);
        add_entry("ram_rd_b2b", OP_RD, 32'h0000_0100, 4'hF, 32'h0, 1'b0, CK_VAL);
        add_entry("gpio_wr_out", OP_WR, 32'hB000_0000, 4'hF, 32'h0, 1'b1, CK_NONE);
        add_entry("gpio_wr_dir", OP_WR, 32'hB000_0004, 4'hF, 32'h0, 1'b1, CK_NONE);
        add_entry("gpio_pins", OP_PINCHK, 32'h0, 4'h0, 32'h0, 1'b0, CK_NONE);
        add_entry("gpio_rd_out", OP_RD, 32'hB000_0000, 4'hF, 32'h0, 1'b0, CK_VAL);
        add_entry("gpio_rd_dir", OP_RD, 32'hB000_0004, 4'hF, 32'h0, 1'b0, CK_VAL);
        add_entry("gpio_drive", OP_PIN, 32'h0, 4'h0, 32'h0, 1'b1, CK_NONE);
        add_entry("gpio_sync", OP_IDLE, 32'h0, 4'h0, 32'd1, 1'b0, CK_NONE);
        add_entry("gpio_rd_in", OP_RD, 32'hB000_0008, 4'hF, 32'h0, 1'b0, CK_VAL);
        add_entry("gpio_rd_gap", OP_RD, 32'hB000_0010, 4'hF, 32'h0, 1'b0, CK_VAL);
        add_entry("tick_wr_count", OP_WR, 32'hC000_0000, 4'hF, 32'h0, 1'b1, CK_NONE);
        add_entry("tick_rd_count", OP_RD, 32'hC000_0000, 4'hF, 32'h0, 1'b0, CK_VAL);
        add_entry("tick_rd_ctrl", OP_RD, 32'hC000_0004, 4'hF, 32'h0, 1'b0, CK_VAL);
        add_entry("tick_enable", OP_WR, 32'hC000_0004, 4'hF, 32'd1, 1'b0, CK_NONE);
        add_entry("tick_rd_en", OP_RD, 32'hC000_0004, 4'hF, 32'h0, 1'b0, CK_VAL);
        add_entry("tick_ref", OP_RD, 32'hC000_0000, 4'hF, 32'h0, 1'b0, CK_REF);
        add_entry("tick_wait", OP_IDLE, 32'h0, 4'h0, 32'd5, 1'b0, CK_NONE);
        add_entry("tick_delta_gap", OP_RD, 32'hC000_0000, 4'hF, 32'h0, 1'b0, CK_DELTA);
        add_entry("tick_delta_b2b", OP_RD, 32'hC000_0000, 4'hF, 32'h0, 1'b0, CK_DELTA);
        add_entry("unm_rd", OP_RD, 32'h5000_0010, 4'hF, 32'h0, 1'b0, CK_VAL);
        add_entry("unm_wr_ram", OP_WR, 32'h5000_0010, 4'hF, 32'h0, 1'b1, CK_NONE);
        add_entry("unm_wr_gpio", OP_WR, 32'h5000_0000, 4'hF, 32'h0, 1'b1, CK_NONE);
        add_entry("unm_ram_kept", OP_RD, 32'h0000_0010, 4'hF, 32'h0, 1'b0, CK_VAL);
        add_entry("unm_pins_kept", OP_PINCHK, 32'h0, 4'h0, 32'h0, 1'b0, CK_NONE);
        add_entry("unm_out_kept", OP_RD, 32'hB000_0000, 4'hF, 32'h0, 1'b0, CK_VAL);
        add_entry("unm_tick_kept", OP_RD, 32'hC000_0000, 4'hF, 32'h0, 1'b0, CK_DELTA);
        table_len = tbl.size();
    endfunction

    task automatic drop_strobes();
        m_req.read  <= 1'b0;
        m_req.write <= 1'b0;
    endtask

    task automatic run_entry(input int i);
        entry_t e;
        string  name;
        word_t  wd;
        word_t  got;
        word_t  exp;
        int     cycles;
        int     exp_cycles;
        logic   stalled;
        e    = tbl[i];
        name = tbl_name[i];
        wd   = e.data;
        if (e.rnd) begin
            rng = xorshift32(rng);
            wd  = rng;
        end
        case (e.op)
            OP_WR, OP_RD: begin
                @(posedge clk);
                m_req.address    <= e.addr;
                m_req.byteenable <= e.be;
                m_req.read       <= (e.op == OP_RD);
                m_req.write      <= (e.op == OP_WR);
                m_req.wrdata     <= wd;
                cycles  = 0;
                stalled = 1'b1;
                got     = '0;
                // the access completes on the first rising edge with stall low
                while (stalled) begin
                    @(negedge clk);
                    cycles  = cycles + 1;
                    stalled = m_rsp.stall;
                    got     = m_rsp.rddata;
                    if (stalled) begin
                        @(posedge clk);
                    end
                end
                exp_cycles = expected_cycles(e.op == OP_RD, e.addr, e.be);
                n_checks   = n_checks + 1;
                if (cycles != exp_cycles) begin
                    $display("FAIL %s cycles expected %0d actual %0d", name, exp_cycles, cycles);
                    n_errors = n_errors + 1;
                end
                if (e.op == OP_WR) begin
                    apply_write(e.addr, e.be, wd);
                end else if (e.chk == CK_VAL || e.chk == CK_DELTA) begin
                    exp = expected_read(e.addr);
                    if (e.chk == CK_DELTA) begin
                        exp = tick_ref_val + 32'(cyc - tick_ref_cyc); // one count per clock
                    end
                    n_checks = n_checks + 1;
                    if (got !== exp) begin
                        $display("FAIL %s expected %h actual %h", name, exp, got);
                        n_errors = n_errors + 1;
                    end
                end
                if (e.chk == CK_REF || e.chk == CK_DELTA) begin
                    tick_ref_val = got;
                    tick_ref_cyc = cyc;
                end
            end
            OP_PIN: begin
                @(posedge clk);
                drop_strobes();
                gpio_in <= wd;
                pin_m = wd;
            end
            OP_IDLE: begin
                repeat (e.data) begin
                    @(posedge clk);
                    drop_strobes();
                end
            end
            default: begin
                @(posedge clk);
                drop_strobes();
                @(negedge clk);
                n_checks = n_checks + 2;
                if (gpio_out !== out_m) begin
                    $display("FAIL %s gpio_o expected %h actual %h", name, out_m, gpio_out);
                    n_errors = n_errors + 1;
                end
                if (gpio_oe !== dir_m) begin
                    $display("FAIL %s gpio_oe_o expected %h actual %h", name, dir_m, gpio_oe);
                    n_errors = n_errors + 1;
                end
            end
        endcase
    endtask

    initial begin
        m_req   = '0;
        gpio_in = '0;
        arst_n  = 1'b0;
        rng     = 32'h8934;
        out_m   = '0;
        dir_m   = '0;
        pin_m   = '0;
        count_m = '0;
        en_m    = 1'b0;
        build_table();
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        for (int i = 0; i < table_len; i++) begin
            run_entry(i);
        end
        @(posedge clk);
        drop_strobes();
        @(posedge clk);
        $display("checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // four cycles per entry covers the slowest access with room to spare
    initial begin
        wait (table_len > 0);
        repeat (table_len * 4 + 50) @(posedge clk);
        $display("watchdog expired after %0d cycles, the bus stopped responding",
                 table_len * 4 + 50);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* soc_dbus_top.sv */
`timescale 1ns/1ns
`default_nettype none

module soc_dbus_top (
    input  wire                    clk_i,
    input  wire                    arst_n_i,
    input  wire soc_pkg::bus_req_t m_req_i,
    output soc_pkg::bus_rsp_t      m_rsp_o,
    input  wire soc_pkg::word_t    gpio_i,
    output soc_pkg::word_t         gpio_o,
    output soc_pkg::word_t         gpio_oe_o
);
    import soc_pkg::*;

    bus_req_t  ram_req;
    bus_req_t  gpio_req;
    bus_req_t  tick_req;
    bus_rsp_t  ram_rsp;
    bus_rsp_t  gpio_rsp;
    bus_rsp_t  tick_rsp;

    // converter to RAM, whole words only
    ram_addr_t ram_addr;
    word_t     ram_wdata;
    word_t     ram_rdata;
    logic      ram_we;
    logic      ram_re;

    dbus dbus0 (
        .m_req_i    (m_req_i),
        .m_rsp_o    (m_rsp_o),
        .ram_req_o  (ram_req),
        .gpio_req_o (gpio_req),
        .tick_req_o (tick_req),
        .ram_rsp_i  (ram_rsp),
        .gpio_rsp_i (gpio_rsp),
        .tick_rsp_i (tick_rsp)
    );

    bytes_conv mem_conv (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_i       (ram_req),
        .rsp_o       (ram_rsp),
        .ram_addr_o  (ram_addr),
        .ram_wdata_o (ram_wdata),
        .ram_we_o    (ram_we),
        .ram_re_o    (ram_re),
        .ram_rdata_i (ram_rdata)
    );

    word_ram mainram (
        .clk_i   (clk_i),
        .addr_i  (ram_addr),
        .wdata_i (ram_wdata),
        .we_i    (ram_we),
        .re_i    (ram_re),
        .rdata_o (ram_rdata)
    );

    gpio_top gpio_inst (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .req_i     (gpio_req),
        .rsp_o     (gpio_rsp),
        .gpio_i    (gpio_i),
        .gpio_o    (gpio_o),
        .gpio_oe_o (gpio_oe_o)
    );

    ticker ticker_inst (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (tick_req),
        .rsp_o    (tick_rsp)
    );

endmodule

`default_nettype wire

/* dbus.sv */
`timescale 1ns/1ns
`default_nettype none

`include "soc_defines.svh"

module dbus (
    input  wire soc_pkg::bus_req_t m_req_i,
    output soc_pkg::bus_rsp_t      m_rsp_o,
    output soc_pkg::bus_req_t      ram_req_o,
    output soc_pkg::bus_req_t      gpio_req_o,
    output soc_pkg::bus_req_t      tick_req_o,
    input  wire soc_pkg::bus_rsp_t ram_rsp_i,
    input  wire soc_pkg::bus_rsp_t gpio_rsp_i,
    input  wire soc_pkg::bus_rsp_t tick_rsp_i
);
    import soc_pkg::*;

    logic [3:0] sel;
    logic       ram_hit;
    logic       gpio_hit;
    logic       tick_hit;

    // payload goes to every slave, only the strobes are steered
    function automatic bus_req_t gate_req(input bus_req_t req, input logic hit);
        bus_req_t r;
        r       = req;
        r.read  = req.read && hit;
        r.write = req.write && hit;
        return r;
    endfunction

    assign sel      = m_req_i.address[31:28];
    assign ram_hit  = (sel == `SOC_SEL_RAM);
    assign gpio_hit = (sel == `SOC_SEL_GPIO);
    assign tick_hit = (sel == `SOC_SEL_TICK);

    assign ram_req_o  = gate_req(m_req_i, ram_hit);
    assign gpio_req_o = gate_req(m_req_i, gpio_hit);
    assign tick_req_o = gate_req(m_req_i, tick_hit);

    always_comb begin
        if (ram_hit) begin
            m_rsp_o = ram_rsp_i; // the only path that can stall
        end else if (gpio_hit) begin
            m_rsp_o = gpio_rsp_i;
        end else if (tick_hit) begin
            m_rsp_o = tick_rsp_i;
        end else begin
            m_rsp_o = '0; // unmapped reads return zero and complete at once
        end
    end

endmodule

`default_nettype wire

/* ticker.sv */
`timescale 1ns/1ns
`default_nettype none

`include "soc_defines.svh"

module ticker (
    input  wire                    clk_i,
    input  wire                    arst_n_i,
    input  wire soc_pkg::bus_req_t req_i,
    output soc_pkg::bus_rsp_t      rsp_o
);
    import soc_pkg::*;

    word_t      count_q;
    logic       en_q;
    logic [7:0] reg_off;

    assign reg_off = req_i.address[7:0];

    // counts bus clocks, a bus load of COUNT wins over the increment
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q <= '0;
            en_q    <= 1'b0;
        end else begin
            if (req_i.write && (reg_off == `TICK_REG_COUNT)) begin
                count_q <= req_i.wrdata;
            end else if (en_q) begin
                count_q <= count_q + 32'd1;
            end
            if (req_i.write && (reg_off == `TICK_REG_CTRL)) begin
                en_q <= req_i.wrdata[0];
            end
        end
    end

    always_comb begin
        rsp_o.stall = 1'b0;
        case (reg_off)
            `TICK_REG_COUNT: rsp_o.rddata = count_q;
            `TICK_REG_CTRL:  rsp_o.rddata = {31'd0, en_q};
            default:         rsp_o.rddata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* gpio_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "soc_defines.svh"

module gpio_top (
    input  wire                    clk_i,
    input  wire                    arst_n_i,
    input  wire soc_pkg::bus_req_t req_i,
    output soc_pkg::bus_rsp_t      rsp_o,
    input  wire soc_pkg::word_t    gpio_i,
    output soc_pkg::word_t         gpio_o,
    output soc_pkg::word_t         gpio_oe_o
);
    import soc_pkg::*;

    word_t      out_q;
    word_t      dir_q;
    word_t      in_meta_q; // first synchronizer stage
    word_t      in_sync_q;
    logic [7:0] reg_off;

    assign reg_off   = req_i.address[7:0];
    assign gpio_o    = out_q;
    assign gpio_oe_o = dir_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_q     <= '0;
            dir_q     <= '0;
            in_meta_q <= '0;
            in_sync_q <= '0;
        end else begin
            in_meta_q <= gpio_i;
            in_sync_q <= in_meta_q;
            if (req_i.write && (reg_off == `GPIO_REG_OUT)) begin
                out_q <= req_i.wrdata;
            end
            if (req_i.write && (reg_off == `GPIO_REG_DIR)) begin
                dir_q <= req_i.wrdata; // a set bit drives the pin
            end
        end
    end

    always_comb begin
        rsp_o.stall = 1'b0;
        case (reg_off)
            `GPIO_REG_OUT: rsp_o.rddata = out_q;
            `GPIO_REG_DIR: rsp_o.rddata = dir_q;
            `GPIO_REG_IN:  rsp_o.rddata = in_sync_q;
            default:       rsp_o.rddata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* bytes_conv.sv */
`timescale 1ns/1ns
`default_nettype none

`include "soc_defines.svh"

module bytes_conv (
    input  wire                    clk_i,
    input  wire                    arst_n_i,
    input  wire soc_pkg::bus_req_t req_i,
    output soc_pkg::bus_rsp_t      rsp_o,
    output soc_pkg::ram_addr_t     ram_addr_o,
    output soc_pkg::word_t         ram_wdata_o,
    output logic                   ram_we_o,
    output logic                   ram_re_o,
    input  wire soc_pkg::word_t    ram_rdata_i
);
    import soc_pkg::*;

    conv_state_t state_q;
    conv_state_t state_d;
    word_t       merged_d;
    word_t       merged_q;
    logic        full_wr;
    logic        part_wr;

    assign full_wr = req_i.write && (req_i.byteenable == 4'hF);
    assign part_wr = req_i.write && (req_i.byteenable != 4'hF);

    assign ram_addr_o  = req_i.address[`SOC_RAM_AW+1:2];
    assign ram_wdata_o = (state_q == MERGE_WR) ? merged_q : req_i.wrdata;

    // enabled lanes come from the master, the rest from the word read back
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            merged_d[8*i +: 8] = req_i.byteenable[i] ? req_i.wrdata[8*i +: 8]
                                                     : ram_rdata_i[8*i +: 8];
        end
    end

    always_comb begin
        state_d      = state_q;
        ram_re_o     = 1'b0;
        ram_we_o     = 1'b0;
        rsp_o.rddata = ram_rdata_i; // only taken by the master once stall drops
        rsp_o.stall  = 1'b0;
        case (state_q)
            IDLE: begin
                if (req_i.read || part_wr) begin
                    ram_re_o    = 1'b1;
                    rsp_o.stall = 1'b1;
                    state_d     = RD_WAIT;
                end else if (full_wr) begin
                    ram_we_o = 1'b1; // whole word goes straight through
                end
            end
            RD_WAIT: begin
                if (part_wr) begin
                    rsp_o.stall = 1'b1; // old word is here, merge it next edge
                    state_d     = MERGE_WR;
                end else begin
                    state_d = IDLE;
                end
            end
            MERGE_WR: begin
                ram_we_o = 1'b1;
                state_d  = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == RD_WAIT) begin
            merged_q <= merged_d;
        end
    end

endmodule

`default_nettype wire

/* word_ram.sv */
`timescale 1ns/1ns
`default_nettype none

`include "soc_defines.svh"

module word_ram (
    input  wire                clk_i,
    input  wire soc_pkg::ram_addr_t addr_i,
    input  wire soc_pkg::word_t     wdata_i,
    input  wire                we_i,
    input  wire                re_i,
    output soc_pkg::word_t     rdata_o
);
    import soc_pkg::*;

    word_t mem [`SOC_RAM_WORDS];

    // read data shows up one clock after re_i and then holds
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
        if (re_i) begin
            rdata_o <= mem[addr_i];
        end
    end

endmodule

`default_nettype wire

/* soc_pkg.sv */
`default_nettype none

`include "soc_defines.svh"

package soc_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  byte_en_t; // bit n covers bits 8n+7 down to 8n

    typedef logic [`SOC_RAM_AW-1:0] ram_addr_t;

    // master side of the data bus, also what dbus hands each slave
    typedef struct packed {
        addr_t    address;
        byte_en_t byteenable;
        logic     read;
        logic     write;
        word_t    wrdata;
    } bus_req_t;

    typedef struct packed {
        word_t rddata;
        logic  stall; // master holds its request while this is high
    } bus_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        RD_WAIT,
        MERGE_WR
    } conv_state_t;

endpackage

`default_nettype wire

/* soc_defines.svh */
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// main RAM holds whole 32-bit words only
`define SOC_RAM_AW    10
`define SOC_RAM_WORDS 1024

// address bits 31:28 pick the slave on the data bus
`define SOC_SEL_RAM   4'h0
`define SOC_SEL_GPIO  4'hB
`define SOC_SEL_TICK  4'hC

// register offsets are taken from address bits 7:0
`define GPIO_REG_OUT  8'h00
`define GPIO_REG_DIR  8'h04
`define GPIO_REG_IN   8'h08 // synchronized pin levels, read only

`define TICK_REG_COUNT 8'h00
`define TICK_REG_CTRL  8'h04 // bit 0 enables counting

`endif
